// ==== pcie_endpoint_driver.f ====
+incdir+.
pcie_driver_pkg.sv
tlp_rx_decode.sv
host_reg_bank.sv
sys_time.sv
interrupt_ctrl.sv
pcie_endpoint_driver.sv
tb_pcie_endpoint_driver.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, result taken from the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pcie_endpoint_driver \
    -f pcie_endpoint_driver.f \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// ==== tb_pcie_endpoint_driver.sv ====
`timescale 1ns/1ps
`include "pcie_driver_consts.svh"

module tb_pcie_endpoint_driver
    import pcie_driver_pkg::*;
();

    localparam logic [31:0] SEED = 32'h854d;

    logic                  trn_clk;
    logic                  reset;
    logic [`TRN_DW-1:0]    trn_rd;
    logic [`TRN_REM_W-1:0] trn_rrem_n;
    logic                  trn_rsof_n, trn_reof_n, trn_rsrc_rdy_n;
    logic [`BAR_HIT_W-1:0] trn_rbar_hit_n;
    logic                  trn_rdst_rdy_n;
    logic [`PTR_W-1:0]     hw_pointer, sw_pointer;
    logic                  huge_page_free_1, huge_page_free_2;
    huge_page_t            huge_page_1, huge_page_2;
    sys_time_t             sys_time;
    logic                  rx_timestamp_en;
    logic                  cfg_interrupt_rdy_n, cfg_interrupt_n;

    // Expected state
    huge_page_t            exp_hp1, exp_hp2;
    logic [`PTR_W-1:0]     exp_sw_ptr;
    logic                  exp_ts_en;
    sys_time_t             exp_time;             // Reference time of day
    logic                  time_load;            // Host load lands on next edge
    logic [`PTR_W-1:0]     time_val;
    logic                  irq_quiet;            // No request allowed
    logic [`PTR_W-1:0]     hw_ptr_val;
    int                    errors, err_mark, tests_ok, tests_bad;

    pcie_endpoint_driver pcie_endpoint_driver_i (.*);

    always #10 trn_clk = ~trn_clk;               // 50 MHz in simulation

    // --------------------
    // Reference time
    // --------------------
    always @(posedge trn_clk) begin
        if (reset) begin
            exp_time <= '0;
        end else if (time_load) begin
            exp_time <= '{nsecs: time_val[31:0], secs: time_val[63:32]};
        end else if (exp_time.nsecs >= `NSECS_PER_SEC - `NSECS_PER_TICK) begin
            exp_time.nsecs <= exp_time.nsecs + `NSECS_PER_TICK - `NSECS_PER_SEC;
            exp_time.secs  <= exp_time.secs + 32'd1;   // Carry into seconds
        end else begin
            exp_time.nsecs <= exp_time.nsecs + `NSECS_PER_TICK;
        end
    end

    function automatic void report_mismatch(input string name, input logic [64:0] got,
                                            input logic [64:0] exp);
        $display("MISMATCH %s got %h expected %h", name, got, exp);
        errors++;
    endfunction

    function automatic void note_failure(input string what);
        $display("ERROR %s", what);
        errors++;
    endfunction

    // --------------------
    // Checks
    // --------------------
    a_page_1: assert property (@(posedge trn_clk) disable iff (reset)
        huge_page_1.ready == exp_hp1.ready && (!exp_hp1.ready || huge_page_1.addr == exp_hp1.addr))
        else report_mismatch("huge_page_1", $sampled(huge_page_1), $sampled(exp_hp1));
    a_page_2: assert property (@(posedge trn_clk) disable iff (reset)
        huge_page_2.ready == exp_hp2.ready && (!exp_hp2.ready || huge_page_2.addr == exp_hp2.addr))
        else report_mismatch("huge_page_2", $sampled(huge_page_2), $sampled(exp_hp2));
    a_sw_ptr: assert property (@(posedge trn_clk) disable iff (reset) sw_pointer == exp_sw_ptr)
        else report_mismatch("sw_pointer", $sampled(sw_pointer), $sampled(exp_sw_ptr));
    a_ts_en: assert property (@(posedge trn_clk) disable iff (reset) rx_timestamp_en == exp_ts_en)
        else report_mismatch("rx_timestamp_en", $sampled(rx_timestamp_en), $sampled(exp_ts_en));
    a_rdst_rdy: assert property (@(posedge trn_clk) disable iff (reset)
        trn_rdst_rdy_n == 1'b0)                  // Receive side always listens
        else report_mismatch("trn_rdst_rdy_n", $sampled(trn_rdst_rdy_n), 65'd0);
    a_time: assert property (@(posedge trn_clk) disable iff (reset) sys_time == exp_time)
        else report_mismatch("sys_time", $sampled(sys_time), $sampled(exp_time));
    a_irq_quiet: assert property (@(posedge trn_clk) disable iff (reset)
        irq_quiet |-> cfg_interrupt_n)
        else report_mismatch("cfg_interrupt_n", 65'd0, 65'd1);
    a_irq_hold: assert property (@(posedge trn_clk) disable iff (reset)
        (!cfg_interrupt_n && cfg_interrupt_rdy_n) |=> !cfg_interrupt_n)
        else note_failure("cfg_interrupt_n rose before cfg_interrupt_rdy_n was seen low");
    a_irq_ack: assert property (@(posedge trn_clk) disable iff (reset)
        (!cfg_interrupt_n && !cfg_interrupt_rdy_n) |=> cfg_interrupt_n)
        else note_failure("cfg_interrupt_n stayed low after the acknowledge");

    // --------------------
    // Stimulus tasks
    // --------------------
    task automatic send_tlp(input logic hit, input logic [1:0] fmt, input logic [9:0] len,
                            input logic [5:0] ofs, input logic [63:0] data);
        logic accept;
        accept = hit && (fmt == `TLP_FMT_MWR32) && (len == `TLP_LEN_QW);
        @(posedge trn_clk);
        trn_rsof_n     <= 1'b0;                  // Header beat
        trn_rsrc_rdy_n <= 1'b0;
        trn_rbar_hit_n <= {6'h3f, !hit};
        trn_rd         <= {1'b0, fmt, `TLP_TYPE_MEM, 14'd0, len, 32'h0000_00ff};
        @(posedge trn_clk);
        trn_rsof_n <= 1'b1;
        trn_rd     <= {23'd0, ofs, 3'd0, data[31:0]};   // Address and low data DW
        @(posedge trn_clk);
        trn_reof_n <= 1'b0;
        trn_rrem_n <= 8'h0f;                     // Only upper DW carries data
        trn_rd     <= {data[63:32], 32'd0};
        @(posedge trn_clk);
        trn_reof_n     <= 1'b1;
        trn_rsrc_rdy_n <= 1'b1;
        trn_rrem_n     <= 8'h00;
        trn_rbar_hit_n <= '1;
        time_load      <= accept && (ofs == `REG_TIME);
        time_val       <= data;
        @(posedge trn_clk);                      // Two cycles after the end beat
        time_load <= 1'b0;
        if (accept) begin
            case (ofs)
                `REG_HP1_ADDR: exp_hp1    <= '{addr: data, ready: 1'b1};
                `REG_HP2_ADDR: exp_hp2    <= '{addr: data, ready: 1'b1};
                `REG_SW_PTR:   exp_sw_ptr <= data;
                `REG_CTRL:     exp_ts_en  <= data[`CTRL_TS_EN];
                default: ;
            endcase
        end
    endtask

    task automatic free_page(input int slot);
        @(posedge trn_clk);
        huge_page_free_1 <= (slot == 1);
        huge_page_free_2 <= (slot == 2);
        @(posedge trn_clk);
        huge_page_free_1 <= 1'b0;
        huge_page_free_2 <= 1'b0;
        if (slot == 1) begin
            exp_hp1.ready <= 1'b0;
        end else begin
            exp_hp2.ready <= 1'b0;
        end
    endtask

    task automatic wait_irq(input logic level, input int limit);
        int n;
        n = 0;
        @(negedge trn_clk);                      // Sample away from the edge
        while (cfg_interrupt_n !== level && n < limit) begin
            @(negedge trn_clk);
            n++;
        end
        if (cfg_interrupt_n !== level) begin
            note_failure($sformatf("timed out waiting for cfg_interrupt_n = %0d", level));
        end
    endtask

    task automatic ack_irq();
        int unsigned delay;
        delay = $urandom_range(8, 1);
        repeat (delay) @(posedge trn_clk);       // Core busy for a while
        cfg_interrupt_rdy_n <= 1'b0;
        @(posedge trn_clk);
        cfg_interrupt_rdy_n <= 1'b1;
        irq_quiet           <= 1'b1;             // Request ends on this edge
    endtask

    task automatic start_test();
        err_mark = errors;
    endtask

    task automatic end_test(input string name);
        if (errors == err_mark) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, errors - err_mark);
        end
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        void'($urandom(SEED));
        trn_clk = 1'b0;
        reset = 1'b1;
        trn_rd = '0;
        trn_rrem_n = '0;
        trn_rsof_n = 1'b1;
        trn_reof_n = 1'b1;
        trn_rsrc_rdy_n = 1'b1;
        trn_rbar_hit_n = '1;
        hw_pointer = '0;
        huge_page_free_1 = 1'b0;
        huge_page_free_2 = 1'b0;
        cfg_interrupt_rdy_n = 1'b1;
        exp_hp1 = '0;
        exp_hp2 = '0;
        exp_sw_ptr = '0;
        exp_ts_en = 1'b0;
        time_load = 1'b0;
        time_val = '0;
        irq_quiet = 1'b1;
        errors = 0;
        tests_ok = 0;
        tests_bad = 0;

        start_test();
        repeat (2) @(posedge trn_clk);
        reset <= 1'b0;
        repeat (4) @(posedge trn_clk);
        end_test("reset state");

        start_test();
        send_tlp(1'b1, `TLP_FMT_MWR32, `TLP_LEN_QW, `REG_HP1_ADDR, {$urandom, $urandom});
        send_tlp(1'b1, `TLP_FMT_MWR32, `TLP_LEN_QW, `REG_HP2_ADDR, {$urandom, $urandom});
        free_page(1);                            // Slot 2 keeps its flag
        repeat (2) @(posedge trn_clk);
        free_page(2);
        send_tlp(1'b1, `TLP_FMT_MWR32, `TLP_LEN_QW, `REG_HP1_ADDR, {$urandom, $urandom});
        end_test("huge page write and free");

        start_test();
        send_tlp(1'b0, `TLP_FMT_MWR32, `TLP_LEN_QW, `REG_SW_PTR, {$urandom, $urandom});
        send_tlp(1'b1, 2'b00, `TLP_LEN_QW, `REG_HP2_ADDR, {$urandom, $urandom});
        send_tlp(1'b1, `TLP_FMT_MWR32, 10'd1, `REG_TIME, {$urandom, $urandom});
        end_test("ignored TLPs");

        start_test();
        send_tlp(1'b1, `TLP_FMT_MWR32, `TLP_LEN_QW, `REG_TIME,
                 {$urandom, $urandom % `NSECS_PER_SEC});
        repeat (8) @(posedge trn_clk);
        send_tlp(1'b1, `TLP_FMT_MWR32, `TLP_LEN_QW, `REG_TIME,
                 {$urandom, `NSECS_PER_SEC - 32'd8});   // Rolls over two ticks later
        repeat (4) @(posedge trn_clk);
        end_test("system time");

        start_test();
        hw_ptr_val = {$urandom, $urandom} | 64'h1;
        hw_pointer <= hw_ptr_val;                // Differs, but disabled
        repeat (6) @(posedge trn_clk);
        send_tlp(1'b1, `TLP_FMT_MWR32, `TLP_LEN_QW, `REG_SW_PTR, hw_ptr_val);
        send_tlp(1'b1, `TLP_FMT_MWR32, `TLP_LEN_QW, `REG_CTRL, 64'h3);
        repeat (6) @(posedge trn_clk);           // Equal pointers stay quiet
        send_tlp(1'b1, `TLP_FMT_MWR32, `TLP_LEN_QW, `REG_SW_PTR, hw_ptr_val + 64'd1);
        irq_quiet <= 1'b0;
        wait_irq(1'b0, 2);
        ack_irq();
        wait_irq(1'b1, 2);
        repeat (8) @(posedge trn_clk);           // No second request
        send_tlp(1'b1, `TLP_FMT_MWR32, `TLP_LEN_QW, `REG_SW_PTR, hw_ptr_val + 64'd2);
        irq_quiet <= 1'b0;
        wait_irq(1'b0, 2);
        ack_irq();
        wait_irq(1'b1, 2);
        send_tlp(1'b1, `TLP_FMT_MWR32, `TLP_LEN_QW, `REG_CTRL, 64'h0);
        send_tlp(1'b1, `TLP_FMT_MWR32, `TLP_LEN_QW, `REG_SW_PTR, hw_ptr_val + 64'd3);
        repeat (6) @(posedge trn_clk);
        end_test("interrupt handshake");

        $display("tests ok %0d, tests failed %0d, errors %0d", tests_ok, tests_bad, errors);
        if (errors == 0 && tests_bad == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #200_000;
        $display("simulation watchdog expired before the tests finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== pcie_endpoint_driver.sv ====
`timescale 1ns/1ps
`include "pcie_driver_consts.svh"

module pcie_endpoint_driver
    import pcie_driver_pkg::*;
(
    input  logic                  trn_clk,
    input  logic                  reset,

    // Receive local-link
    input  logic [`TRN_DW-1:0]    trn_rd,
    input  logic [`TRN_REM_W-1:0] trn_rrem_n,
    input  logic                  trn_rsof_n,
    input  logic                  trn_reof_n,
    input  logic                  trn_rsrc_rdy_n,
    input  logic [`BAR_HIT_W-1:0] trn_rbar_hit_n,
    output logic                  trn_rdst_rdy_n,

    // Producer side
    input  logic [`PTR_W-1:0]     hw_pointer,
    input  logic                  huge_page_free_1,
    input  logic                  huge_page_free_2,
    output huge_page_t            huge_page_1,
    output huge_page_t            huge_page_2,
    output logic [`PTR_W-1:0]     sw_pointer,
    output sys_time_t             sys_time,
    output logic                  rx_timestamp_en,

    // Configuration port interrupt
    input  logic                  cfg_interrupt_rdy_n,
    output logic                  cfg_interrupt_n
);

    trn_rx_t rx;                                   // Receive beat, active high
    reg_wr_t reg_wr;                               // Decoded host write
    logic    sw_ptr_written;
    logic    int_enable;

    // --------------------
    // Receive port packing
    // --------------------
    assign rx = '{rd:       trn_rd,
                  rrem_n:   trn_rrem_n,
                  sof:      !trn_rsof_n,
                  eof:      !trn_reof_n,
                  valid:    !trn_rsrc_rdy_n,
                  bar0_hit: !trn_rbar_hit_n[`BAR_CTRL]};

    assign trn_rdst_rdy_n = 1'b0;                  // Never back-pressure

    // --------------------
    // Blocks
    // --------------------
    tlp_rx_decode tlp_rx_decode_i (
        .trn_clk (trn_clk),
        .reset   (reset),
        .rx      (rx),
        .reg_wr  (reg_wr)
    );

    host_reg_bank host_reg_bank_i (
        .trn_clk          (trn_clk),
        .reset            (reset),
        .reg_wr           (reg_wr),
        .huge_page_free_1 (huge_page_free_1),
        .huge_page_free_2 (huge_page_free_2),
        .huge_page_1      (huge_page_1),
        .huge_page_2      (huge_page_2),
        .sw_pointer       (sw_pointer),
        .sw_ptr_written   (sw_ptr_written),
        .int_enable       (int_enable),
        .rx_timestamp_en  (rx_timestamp_en)
    );

    sys_time sys_time_i (
        .trn_clk  (trn_clk),
        .reset    (reset),
        .reg_wr   (reg_wr),
        .sys_time (sys_time)
    );

    interrupt_ctrl interrupt_ctrl_i (
        .trn_clk             (trn_clk),
        .reset               (reset),
        .int_enable          (int_enable),
        .hw_pointer          (hw_pointer),
        .sw_pointer          (sw_pointer),
        .sw_ptr_written      (sw_ptr_written),
        .cfg_interrupt_rdy_n (cfg_interrupt_rdy_n),
        .cfg_interrupt_n     (cfg_interrupt_n)
    );

endmodule

// ==== interrupt_ctrl.sv ====
`timescale 1ns/1ps
`include "pcie_driver_consts.svh"

module interrupt_ctrl (
    input  logic              trn_clk,
    input  logic              reset,
    input  logic              int_enable,          // Host interrupt enable
    input  logic [`PTR_W-1:0] hw_pointer,          // Producer position
    input  logic [`PTR_W-1:0] sw_pointer,          // Host position
    input  logic              sw_ptr_written,      // Host moved its pointer
    input  logic              cfg_interrupt_rdy_n, // Core took the request
    output logic              cfg_interrupt_n      // Request, active low
);

    logic armed;                                   // One interrupt per pointer update
    logic req_cond;
    logic fire;

    // --------------------
    // Request condition
    // --------------------
    assign req_cond = armed && int_enable && (hw_pointer != sw_pointer);
    assign fire     = cfg_interrupt_n && req_cond; // Only from idle

    always_ff @(posedge trn_clk) begin
        if (reset) begin
            armed <= 1'b1;                         // Ready for the first request
        end else if (fire) begin
            armed <= 1'b0;
        end else if (sw_ptr_written) begin
            armed <= 1'b1;                         // Rearm on host update
        end
    end

    // --------------------
    // Core handshake
    // --------------------
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            cfg_interrupt_n <= 1'b1;
        end else if (cfg_interrupt_n) begin
            if (fire) begin
                cfg_interrupt_n <= 1'b0;           // Assert request
            end
        end else if (!cfg_interrupt_rdy_n) begin
            cfg_interrupt_n <= 1'b1;               // Core acknowledged
        end
    end

    // Request drops only after the core accepted it
    a_hold_until_rdy: assert property (@(posedge trn_clk) disable iff (reset)
        $rose(cfg_interrupt_n) |-> $past(!cfg_interrupt_rdy_n));

endmodule

// ==== sys_time.sv ====
`timescale 1ns/1ps
`include "pcie_driver_consts.svh"

module sys_time
    import pcie_driver_pkg::*;
(
    input  logic      trn_clk,
    input  logic      reset,
    input  reg_wr_t   reg_wr,                   // Host load of the time
    output sys_time_t sys_time                  // Current time of day
);

    logic             time_hit;
    logic [`DW_W-1:0] nsecs_next;               // One tick ahead
    logic             sec_wrap;

    // --------------------
    // Tick arithmetic
    // --------------------
    assign time_hit   = reg_wr.valid && (reg_wr.offset == `REG_TIME);
    assign nsecs_next = sys_time.nsecs + `NSECS_PER_TICK;
    assign sec_wrap   = (nsecs_next >= `NSECS_PER_SEC);  // Crossed a second

    always_ff @(posedge trn_clk) begin
        if (reset) begin
            sys_time <= '0;
        end else if (time_hit) begin
            sys_time.nsecs <= reg_wr.data[`DW_W-1:0];    // Low DW
            sys_time.secs  <= reg_wr.data[`PTR_W-1:`DW_W];
        end else if (sec_wrap) begin
            sys_time.nsecs <= nsecs_next - `NSECS_PER_SEC;
            sys_time.secs  <= sys_time.secs + 1'b1;
        end else begin
            sys_time.nsecs <= nsecs_next;               // Free running
        end
    end

    // Nanoseconds always normalized
    a_nsecs_range: assert property (@(posedge trn_clk) disable iff (reset)
        sys_time.nsecs < `NSECS_PER_SEC);

endmodule

// ==== host_reg_bank.sv ====
`timescale 1ns/1ps
`include "pcie_driver_consts.svh"

module host_reg_bank
    import pcie_driver_pkg::*;
(
    input  logic              trn_clk,
    input  logic              reset,
    input  reg_wr_t           reg_wr,           // From the TLP decoder
    input  logic              huge_page_free_1, // Consumer done with page 1
    input  logic              huge_page_free_2, // Consumer done with page 2
    output huge_page_t        huge_page_1,
    output huge_page_t        huge_page_2,
    output logic [`PTR_W-1:0] sw_pointer,
    output logic              sw_ptr_written,   // Pulse with each pointer update
    output logic              int_enable,
    output logic              rx_timestamp_en
);

    logic [`PTR_W-1:0] page_addr [2];           // Slot addresses
    logic [1:0]        page_ready;
    logic [1:0]        page_hit;                // Host write to slot
    logic [1:0]        page_free;
    logic              sw_ptr_hit;
    logic              ctrl_hit;

    // --------------------
    // Offset decode
    // --------------------
    assign page_hit[0] = reg_wr.valid && (reg_wr.offset == `REG_HP1_ADDR);
    assign page_hit[1] = reg_wr.valid && (reg_wr.offset == `REG_HP2_ADDR);
    assign sw_ptr_hit  = reg_wr.valid && (reg_wr.offset == `REG_SW_PTR);
    assign ctrl_hit    = reg_wr.valid && (reg_wr.offset == `REG_CTRL);
    // REG_TIME belongs to the time counter

    assign page_free = {huge_page_free_2, huge_page_free_1};

    // --------------------
    // Huge page slots
    // --------------------
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            page_ready <= 2'b00;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (page_hit[i]) begin
                    page_ready[i] <= 1'b1;      // Host handed the page over
                end else if (page_free[i]) begin
                    page_ready[i] <= 1'b0;      // Write wins over a same-cycle free
                end
            end
        end
    end

    always_ff @(posedge trn_clk) begin
        for (int i = 0; i < 2; i++) begin
            if (page_hit[i]) begin
                page_addr[i] <= reg_wr.data;
            end
        end
    end

    // --------------------
    // Pointer and control
    // --------------------
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            sw_pointer      <= '0;
            sw_ptr_written  <= 1'b0;
            int_enable      <= 1'b0;
            rx_timestamp_en <= 1'b0;
        end else begin
            sw_ptr_written <= sw_ptr_hit;       // Aligned with the new pointer
            if (sw_ptr_hit) begin
                sw_pointer <= reg_wr.data;
            end
            if (ctrl_hit) begin
                int_enable      <= reg_wr.data[`CTRL_INT_EN];
                rx_timestamp_en <= reg_wr.data[`CTRL_TS_EN];
            end
        end
    end

    assign huge_page_1 = '{addr: page_addr[0], ready: page_ready[0]};
    assign huge_page_2 = '{addr: page_addr[1], ready: page_ready[1]};

    // Consumer only frees pages it was given
    a_free_owned: assert property (@(posedge trn_clk) disable iff (reset)
        (page_free & ~page_ready) == 2'b00);

endmodule

// ==== tlp_rx_decode.sv ====
`timescale 1ns/1ps
`include "pcie_driver_consts.svh"

module tlp_rx_decode
    import pcie_driver_pkg::*;
(
    input  logic     trn_clk,
    input  logic     reset,
    input  trn_rx_t  rx,                       // Receive beat, active-high strobes
    output reg_wr_t  reg_wr                    // Decoded register write
);

    // Beat position inside the current TLP
    typedef enum logic [1:0] {
        ST_HDR,                                // Waiting for start beat
        ST_ADDR,                               // Header DW2 plus first data DW
        ST_DATA                                // Second data DW
    } state_t;

    state_t                state;
    logic                  hdr_ok;             // Start beat passed every check
    logic                  start_ok;
    logic                  addr_beat;
    logic                  data_end;
    logic [`DW_W-1:0]      hdr_dw0;
    logic [`DW_W-1:0]      data_lo;            // First data DW held for the end beat
    logic                  wr_valid;
    logic [`REG_OFS_W-1:0] wr_offset;
    logic [`PTR_W-1:0]     wr_data;

    // --------------------
    // Start beat checks
    // --------------------
    assign hdr_dw0  = rx.rd[`TRN_DW-1:`DW_W];  // DW0 rides in the upper half
    assign start_ok = rx.bar0_hit
                   && (hdr_dw0[30:29] == `TLP_FMT_MWR32)
                   && (hdr_dw0[28:24] == `TLP_TYPE_MEM)
                   && (hdr_dw0[9:0]   == `TLP_LEN_QW);

    // Beats that carry payload, only outside a start beat
    assign addr_beat = rx.valid && !rx.sof && (state == ST_ADDR);
    assign data_end  = rx.valid && !rx.sof && (state == ST_DATA) && rx.eof;

    // --------------------
    // Beat tracker
    // --------------------
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            state    <= ST_HDR;
            hdr_ok   <= 1'b0;
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= 1'b0;                  // Single-cycle strobe
            if (rx.valid) begin
                if (rx.sof) begin              // Restart on any new frame
                    hdr_ok <= start_ok;
                    state  <= rx.eof ? ST_HDR : ST_ADDR;
                end else begin
                    case (state)
                        ST_ADDR: state <= rx.eof ? ST_HDR : ST_DATA;  // Short TLP drops out
                        ST_DATA: begin
                            if (rx.eof) begin
                                wr_valid <= hdr_ok;
                                state    <= ST_HDR;
                            end
                        end
                        default: state <= ST_HDR;   // Stray beat without sof
                    endcase
                end
            end
        end
    end

    // --------------------
    // Payload capture
    // --------------------
    always_ff @(posedge trn_clk) begin
        if (addr_beat) begin
            wr_offset <= rx.rd[`DW_W + `REG_ADDR_LSB +: `REG_OFS_W];  // Quadword index
            data_lo   <= rx.rd[`DW_W-1:0];
        end
        if (data_end) begin
            wr_data <= {rx.rd[`TRN_DW-1:`DW_W], data_lo};           // Wire order kept
        end
    end

    assign reg_wr = '{valid: wr_valid, offset: wr_offset, data: wr_data};

    // Strobe never stretches into a second cycle
    a_wr_single: assert property (@(posedge trn_clk) disable iff (reset)
        reg_wr.valid |=> !reg_wr.valid);

    // A write only comes out of a sampled end beat
    a_wr_after_eof: assert property (@(posedge trn_clk) disable iff (reset)
        reg_wr.valid |-> $past(rx.valid && rx.eof));

endmodule

// ==== pcie_driver_pkg.sv ====
`include "pcie_driver_consts.svh"

package pcie_driver_pkg;

    // --------------------
    // Receive local-link
    // --------------------
    // Strobes are active high once inside the design
    typedef struct packed {
        logic [`TRN_DW-1:0]    rd;         // Beat data
        logic [`TRN_REM_W-1:0] rrem_n;     // Remainder as on the core
        logic                  sof;        // Start of frame
        logic                  eof;        // End of frame
        logic                  valid;      // Source ready
        logic                  bar0_hit;   // TLP targets the control BAR
    } trn_rx_t;

    // --------------------
    // Register access
    // --------------------
    typedef struct packed {
        logic                  valid;      // One-cycle write strobe
        logic [`REG_OFS_W-1:0] offset;     // Quadword offset into BAR0
        logic [`PTR_W-1:0]     data;       // First data DW in low half
    } reg_wr_t;

    // One receive huge page slot
    typedef struct packed {
        logic [`PTR_W-1:0]     addr;       // Host physical address
        logic                  ready;      // Page owned by hardware
    } huge_page_t;

    // --------------------
    // Time of day
    // --------------------
    typedef struct packed {
        logic [`DW_W-1:0]      nsecs;      // Always below one second
        logic [`DW_W-1:0]      secs;
    } sys_time_t;

endpackage

// ==== pcie_driver_consts.svh ====
`ifndef PCIE_DRIVER_CONSTS_SVH
`define PCIE_DRIVER_CONSTS_SVH

// --------------------
// Bus widths
// --------------------
`define TRN_DW          64                 // Local-link data width
`define TRN_REM_W       8                  // Byte remainder width
`define BAR_HIT_W       7                  // One bit per BAR plus expansion ROM
`define DW_W            32                 // PCIe double word
`define PTR_W           64                 // Host pointers and page addresses
`define REG_OFS_W       6                  // Quadword register offset

// --------------------
// TLP header fields
// --------------------
`define TLP_FMT_MWR32   2'b10              // 3-DW header with data
`define TLP_TYPE_MEM    5'b00000           // Memory request
`define TLP_LEN_QW      10'd2              // Two DWs of payload
`define BAR_CTRL        0                  // BAR0 bit in trn_rbar_hit_n
`define REG_ADDR_LSB    3                  // Address bit of offset LSB

// --------------------
// Register map
// --------------------
`define REG_HP1_ADDR    6'd0               // Huge page 1 address
`define REG_HP2_ADDR    6'd1               // Huge page 2 address
`define REG_SW_PTR      6'd2               // Software pointer
`define REG_TIME        6'd3               // Low DW nsecs, high DW secs
`define REG_CTRL        6'd4               // Interrupt and timestamp enables
`define CTRL_INT_EN     0                  // Interrupt enable bit
`define CTRL_TS_EN      1                  // Timestamp enable bit

// Time base of the 250 MHz clock
`define NSECS_PER_TICK  32'd4
`define NSECS_PER_SEC   32'd1000000000

`endif
